/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/dcache_way_ram.sv
      - logic/dcache_ctrl.sv
      - logic/backing_mem.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - dv/dcache_asserts.sv
      - dv/dcache_tb.sv

/* dcache.f */
logic/dcache_pkg.sv
logic/dcache_way_ram.sv
logic/dcache_ctrl.sv
logic/backing_mem.sv
logic/dcache_top.sv
dv/dcache_asserts.sv
dv/dcache_tb.sv

/* dv/dcache_asserts.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_asserts (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             req_i,
    input  logic                             stall_i,
    input  logic                             mem_valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0]    mem_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]    mem_wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0]    mem_wstrb_i,
    input  logic                             mem_ready_i,
    input  logic                             way0_we_i,
    input  logic                             way1_we_i
);

    int errors = 0;

    // Request held steady until ready
    mem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i)
            && $stable(mem_wdata_i) && $stable(mem_wstrb_i))
    else begin
        $error("memory request dropped or changed before ready");
        errors++;
    end

    mem_drop: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_ready_i |-> mem_valid_i ##1 !mem_valid_i)
    else begin
        $error("memory valid not dropped in the cycle after ready");
        errors++;
    end

    mem_strb: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_wstrb_i == '0 || mem_wstrb_i == '1)
    else begin
        $error("memory strobe neither zero nor all ones");
        errors++;
    end

    one_way: assert property (@(posedge clk_i) disable iff (rst_i)
        !(way0_we_i && way1_we_i))
    else begin
        $error("both way write enables high");
        errors++;
    end

    // No stall once the client goes quiet
    idle_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_i && !stall_i) ##1 !req_i |-> !stall_i)
    else begin
        $error("stall high with no request after a completed one");
        errors++;
    end

endmodule

bind dcache_top dcache_asserts asserts_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .stall_i     (stall_o),
    .mem_valid_i (mem_valid),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_wstrb_i (mem_wstrb),
    .mem_ready_i (mem_ready),
    .way0_we_i   (way0_we),
    .way1_we_i   (way1_we)
);

`default_nettype wire

/* dv/dcache_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int N_WORDS = 24;

    logic              clk_i;
    logic              rst_i;
    logic              req_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    logic [STRB_W-1:0] mask_i;
    logic [DATA_W-1:0] rdata_o;
    logic              stall_o;

    // Expected memory contents, word addressed
    logic [DATA_W-1:0] shadow [2**ADDR_W];
    logic [ADDR_W-1:0] written [N_WORDS];

    logic [31:0]       rng;
    int                pass_cnt;
    int                fail_cnt;
    int                test_start_fails;
    int                stall_cycles;
    logic [DATA_W-1:0] rd_data;

    dcache_top dut_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (req_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .mask_i  (mask_i),
        .rdata_o (rdata_o),
        .stall_o (stall_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Client bytes laid over the old word
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [STRB_W-1:0] mask);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) pass_cnt++;
        else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, act);
            fail_cnt++;
        end
    endtask

    // One request, held while the cache stalls
    task automatic access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [STRB_W-1:0] mask);
        int waited;
        @(posedge clk_i);
        req_i   <= 1'b1;
        addr_i  <= addr;
        wdata_i <= data;
        mask_i  <= mask;
        waited = 0;
        @(negedge clk_i);
        while (stall_o && waited < TIMEOUT) begin
            waited++;
            @(negedge clk_i);
        end
        stall_cycles = waited;
        rd_data      = rdata_o;
        if (stall_o) begin
            $display("Timeout: stall_o stayed high for %0d cycles at address %h", TIMEOUT, addr);
            $display("Test FAILED");
            $finish;
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] mask);
        access(addr, data, mask);
        shadow[addr] = merge_bytes(shadow[addr], data, mask);
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr);
        access(addr, rand32(), '0);
        check_value("rdata_o", shadow[addr], rd_data);
    endtask

    task automatic idle(input int n);
        @(posedge clk_i);
        req_i <= 1'b0;
        repeat (n - 1) @(posedge clk_i);
    endtask

    task automatic end_test(input string name);
        $display("%-12s finished, %0d errors", name, fail_cnt - test_start_fails);
        test_start_fails = fail_cnt;
    endtask

    initial begin
        logic [ADDR_W-1:0]  addr;
        logic [STRB_W-1:0]  mask;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [ADDR_W-1:0]  evict [4];

        clk_i   = 1'b0;
        rst_i   <= 1'b1;
        req_i   <= 1'b0;
        addr_i  <= '0;
        wdata_i <= '0;
        mask_i  <= '0;
        rng              = 32'h4c4b;
        pass_cnt         = 0;
        fail_cnt         = 0;
        test_start_fails = 0;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;

        @(negedge clk_i);
        check_value("stall_o", 32'd0, {31'd0, stall_o});
        read_check(ADDR_W'(rand32()));
        idle(2);
        end_test("reset_state");

        for (int i = 0; i < N_WORDS; i++) begin
            written[i] = ADDR_W'(rand32());
            write_word(written[i], rand32(), '1);
            if (i % 4 == 3) begin
                idle(2);
            end
        end
        for (int i = 0; i < N_WORDS; i++) begin
            read_check(written[i]);
        end
        end_test("full_words");

        // Even rounds go to cold addresses, odd ones to written words
        for (int i = 0; i < 16; i++) begin
            mask = STRB_W'(rand32());
            if (mask == '0) begin
                mask = STRB_W'(1);
            end
            addr = (i % 2 == 0) ? ADDR_W'(rand32()) : written[i];
            write_word(addr, rand32(), mask);
            read_check(addr);
        end
        end_test("partial");

        index = INDEX_W'(rand32());
        tag   = TAG_W'(rand32());
        for (int k = 0; k < 4; k++) begin
            evict[k] = {tag + TAG_W'(k * 37), index};
            write_word(evict[k], rand32(), '1);
        end
        write_word(evict[0], rand32(), 4'b0110);
        write_word(evict[1], rand32(), 4'b1001);
        for (int k = 0; k < 4; k++) begin
            read_check(evict[k]);
        end
        end_test("eviction");

        for (int i = 0; i < 4; i++) begin
            addr = (i < 2) ? ADDR_W'(rand32()) : evict[i];
            read_check(addr);
            read_check(addr);
            check_value("stall_o cycles", 32'd1, stall_cycles);
        end
        idle(3);
        end_test("hit_timing");

        fail_cnt += dut_i.asserts_i.errors;
        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/backing_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module backing_mem (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             valid_i,
    input  logic [dcache_pkg::ADDR_W-1:0]    addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]    wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0]    wstrb_i,
    output logic [dcache_pkg::DATA_W-1:0]    rdata_o,
    output logic                             ready_o
);

    import dcache_pkg::*;

    // All zero at time zero
    logic [DATA_W-1:0] mem_r [2**ADDR_W] = '{default: '0};

    logic [$clog2(MEM_LATENCY+1)-1:0] cnt_r;
    logic                             ready_r;
    logic                             fire;

    // Last wait cycle, access lands as ready rises
    assign fire = valid_i && !ready_r && (cnt_r == MEM_LATENCY - 1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_r   <= '0;
            ready_r <= 1'b0;
        end else begin
            ready_r <= fire;
            if (fire) begin
                cnt_r <= '0;
            end else if (valid_i && !ready_r) begin
                cnt_r <= cnt_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            rdata_o <= mem_r[addr_i];
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    mem_r[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign ready_o = ready_r;

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                             clk_i,
    input  logic                             rst_i,

    // Client
    input  logic                             req_i,
    input  logic [dcache_pkg::ADDR_W-1:0]    addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]    wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0]    mask_i,
    output logic [dcache_pkg::DATA_W-1:0]    rdata_o,
    output logic                             stall_o,

    // Way RAMs
    output logic [dcache_pkg::INDEX_W-1:0]   way_index_o,
    output logic [dcache_pkg::ENTRY_W-1:0]   way_wdata_o,
    output logic [dcache_pkg::STRB_W-1:0]    way_wstrb_o,
    output logic                             way0_we_o,
    output logic                             way1_we_o,
    input  logic [dcache_pkg::ENTRY_W-1:0]   way0_rdata_i,
    input  logic [dcache_pkg::ENTRY_W-1:0]   way1_rdata_i,

    // Backing memory
    output logic                             mem_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0]    mem_addr_o,
    output logic [dcache_pkg::DATA_W-1:0]    mem_wdata_o,
    output logic [dcache_pkg::STRB_W-1:0]    mem_wstrb_o,
    input  logic [dcache_pkg::DATA_W-1:0]    mem_rdata_i,
    input  logic                             mem_ready_i
);

    import dcache_pkg::*;

    ctrl_state_t state_r;
    ctrl_state_t state_next;

    // Per-way line state, indexed [way][set]
    logic [1:0][SETS-1:0] valid_r;
    logic [1:0][SETS-1:0] dirty_r;
    // Way to replace next
    logic [SETS-1:0]      lru_r;

    logic [INDEX_W-1:0]       index;
    logic [TAG_W-1:0]         tag;
    logic [1:0][TAG_W-1:0]    rtag;
    logic [1:0][DATA_W-1:0]   rdat;

    logic [1:0] way_hit;
    logic       hit;
    logic       hit_way;
    logic       lookup_hit;
    logic       victim;
    logic       victim_dirty;
    logic       is_write;
    logic       full_write;
    logic       alloc;
    logic       wb_done;
    logic       fill_done;
    logic       write_en;
    logic       write_way;

    logic [DATA_W-1:0] fill_data;

    logic [ADDR_W-1:0] mem_addr_r;
    logic [DATA_W-1:0] mem_wdata_r;

    assign index = addr_i[INDEX_W-1:0];
    assign tag   = addr_i[ADDR_W-1:INDEX_W];

    assign {rtag[0], rdat[0]} = way0_rdata_i;
    assign {rtag[1], rdat[1]} = way1_rdata_i;

    assign way_hit[0] = valid_r[0][index] && (rtag[0] == tag);
    assign way_hit[1] = valid_r[1][index] && (rtag[1] == tag);

    assign hit        = |way_hit;
    // Way 0 wins if both ever match
    assign hit_way    = !way_hit[0];
    assign lookup_hit = (state_r == ST_LOOKUP) && hit;

    assign victim       = lru_r[index];
    assign victim_dirty = dirty_r[victim][index];

    assign is_write   = |mask_i;
    assign full_write = &mask_i;

    // Full word onto a clean victim needs no memory traffic
    assign alloc     = (state_r == ST_LOOKUP) && !hit && !victim_dirty && full_write;
    assign wb_done   = (state_r == ST_WRITEBACK) && mem_ready_i;
    assign fill_done = (state_r == ST_FILL) && mem_ready_i;

    // Fill word with the client bytes laid over it
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            fill_data[b*8 +: 8] = mask_i[b] ? wdata_i[b*8 +: 8] : mem_rdata_i[b*8 +: 8];
        end
    end

    // Way RAM side
    assign way_index_o = index;
    assign way_wdata_o = {tag, (state_r == ST_FILL) ? fill_data : wdata_i};
    assign way_wstrb_o = lookup_hit ? mask_i : {STRB_W{1'b1}};

    assign write_en  = (lookup_hit && is_write) || alloc || fill_done;
    assign write_way = lookup_hit ? hit_way : victim;
    assign way0_we_o = write_en && !write_way;
    assign way1_we_o = write_en && write_way;

    assign rdata_o = (state_r == ST_FILL) ? fill_data : rdat[hit_way];

    // Memory side
    assign mem_valid_o = (state_r == ST_WRITEBACK) || (state_r == ST_FILL);
    assign mem_addr_o  = mem_addr_r;
    assign mem_wdata_o = mem_wdata_r;
    assign mem_wstrb_o = (state_r == ST_WRITEBACK) ? {STRB_W{1'b1}} : {STRB_W{1'b0}};

    always_comb begin
        state_next = state_r;
        stall_o    = 1'b1;

        case (state_r)
            ST_IDLE: begin
                stall_o = req_i;
                if (req_i) begin
                    state_next = ST_LOOKUP;
                end
            end

            ST_LOOKUP: begin
                if (hit || alloc) begin
                    stall_o    = 1'b0;
                    state_next = ST_IDLE;
                end else if (victim_dirty) begin
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_FILL;
                end
            end

            // Back to lookup so valid drops for a cycle and the victim is seen clean
            ST_WRITEBACK: begin
                if (mem_ready_i) begin
                    state_next = ST_LOOKUP;
                end
            end

            ST_FILL: begin
                if (mem_ready_i) begin
                    stall_o    = 1'b0;
                    state_next = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r <= ST_IDLE;
            valid_r <= '0;
            dirty_r <= '0;
            lru_r   <= '0;
        end else begin
            state_r <= state_next;

            if (lookup_hit) begin
                lru_r[index] <= !hit_way;
                if (is_write) begin
                    dirty_r[hit_way][index] <= 1'b1;
                end
            end

            if (alloc || fill_done) begin
                valid_r[victim][index] <= 1'b1;
                dirty_r[victim][index] <= is_write;
                lru_r[index]           <= !victim;
            end

            // Memory now holds the victim
            if (wb_done) begin
                dirty_r[victim][index] <= 1'b0;
            end
        end
    end

    // Memory request, held until ready
    always_ff @(posedge clk_i) begin
        if (state_r == ST_LOOKUP) begin
            mem_addr_r  <= victim_dirty ? {rtag[victim], index} : addr_i;
            mem_wdata_r <= rdat[victim];
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Word address, bits 18 to 2 of the byte address
    localparam int ADDR_W = 17;

    // Geometry, one word per set
    localparam int INDEX_W = 8;
    localparam int TAG_W   = ADDR_W - INDEX_W;
    localparam int SETS    = 1 << INDEX_W;

    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Way RAM entry is {tag, data}
    localparam int ENTRY_W = TAG_W + DATA_W;

    // Cycles from valid rising to the ready pulse
    localparam int MEM_LATENCY = 4;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL
    } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/dcache_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_top (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             req_i,
    input  logic [dcache_pkg::ADDR_W-1:0]    addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]    wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0]    mask_i,
    output logic [dcache_pkg::DATA_W-1:0]    rdata_o,
    output logic                             stall_o
);

    import dcache_pkg::*;

    logic [INDEX_W-1:0] way_index;
    logic [ENTRY_W-1:0] way_wdata;
    logic [STRB_W-1:0]  way_wstrb;
    logic               way0_we;
    logic               way1_we;
    logic [ENTRY_W-1:0] way0_rdata;
    logic [ENTRY_W-1:0] way1_rdata;

    logic               mem_valid;
    logic [ADDR_W-1:0]  mem_addr;
    logic [DATA_W-1:0]  mem_wdata;
    logic [STRB_W-1:0]  mem_wstrb;
    logic [DATA_W-1:0]  mem_rdata;
    logic               mem_ready;

    dcache_ctrl ctrl_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .mask_i       (mask_i),
        .rdata_o      (rdata_o),
        .stall_o      (stall_o),
        .way_index_o  (way_index),
        .way_wdata_o  (way_wdata),
        .way_wstrb_o  (way_wstrb),
        .way0_we_o    (way0_we),
        .way1_we_o    (way1_we),
        .way0_rdata_i (way0_rdata),
        .way1_rdata_i (way1_rdata),
        .mem_valid_o  (mem_valid),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_wstrb_o  (mem_wstrb),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    dcache_way_ram way0_i (
        .clk_i   (clk_i),
        .index_i (way_index),
        .we_i    (way0_we),
        .wstrb_i (way_wstrb),
        .wdata_i (way_wdata),
        .rdata_o (way0_rdata)
    );

    dcache_way_ram way1_i (
        .clk_i   (clk_i),
        .index_i (way_index),
        .we_i    (way1_we),
        .wstrb_i (way_wstrb),
        .wdata_i (way_wdata),
        .rdata_o (way1_rdata)
    );

    backing_mem mem_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (mem_valid),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .wstrb_i (mem_wstrb),
        .rdata_o (mem_rdata),
        .ready_o (mem_ready)
    );

endmodule

`default_nettype wire

/* logic/dcache_way_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_way_ram (
    input  logic                             clk_i,
    input  logic [dcache_pkg::INDEX_W-1:0]   index_i,
    input  logic                             we_i,
    input  logic [dcache_pkg::STRB_W-1:0]    wstrb_i,
    input  logic [dcache_pkg::ENTRY_W-1:0]   wdata_i,
    output logic [dcache_pkg::ENTRY_W-1:0]   rdata_o
);

    import dcache_pkg::*;

    logic [ENTRY_W-1:0] mem_r [SETS];

    // Tag goes in with any enabled byte, data field byte by byte
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            if (|wstrb_i) begin
                mem_r[index_i][ENTRY_W-1:DATA_W] <= wdata_i[ENTRY_W-1:DATA_W];
            end
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    mem_r[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, old contents on a same-cycle write
    always_ff @(posedge clk_i) begin
        rdata_o <= mem_r[index_i];
    end

endmodule

`default_nettype wire
